//--- tb.f
verilog/mmu_pkg.sv
verilog/chan_pkg.sv
verilog/tlb_lookup_if.sv
verilog/req_arbiter.sv
verilog/tlb_maint.sv
verilog/tlb_ram.sv
verilog/tlb_lookup.sv
verilog/shared_tlb.sv
testbench/shared_tlb_assertions.sv
testbench/tb_shared_tlb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the shared TLB testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_shared_tlb -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" <<< "$out"; then
	exit 0
fi
exit 1

//--- testbench/tb_shared_tlb.sv
// ====================
// Testbench for the shared TLB
// Model mirrors host writes and predicts each beat per channel
// Host writes are issued only while all channels are idle
// ====================
`default_nettype none

module tb_shared_tlb;

	localparam int PERIOD = 20;
	localparam int RST_CYCLES = 4;
	// Lookups over all tests, each given a generous cycle budget
	localparam int REQ_TOTAL = 136;
	localparam longint WATCHDOG = longint'(PERIOD)
		* (RST_CYCLES + mmu_pkg::INIT_CYCLES + REQ_TOTAL * 8 + 400);
	// Pages that get written, the set 9 ones share one set
	localparam mmu_pkg::vpn_t PAGES [6] = '{20'h12345, 20'h22226, 20'h33337,
		20'h01009, 20'h01019, 20'h01049};

	// Request is {we, asid, vadr}, result is {miss, fault, rwx, padr}
	typedef logic [40:0] req_t;
	typedef logic [32:0] res_t;

	logic clk_g;
	logic rst_i;
	logic [chan_pkg::CHANNELS-1:0] req_valid_i;
	logic [chan_pkg::CHANNELS-1:0] req_ready_o;
	mmu_pkg::vadr_t [chan_pkg::CHANNELS-1:0] req_vadr_i;
	mmu_pkg::asid_t [chan_pkg::CHANNELS-1:0] req_asid_i;
	logic [chan_pkg::CHANNELS-1:0] req_we_i;
	logic wr_valid_i;
	logic wr_ready_o;
	logic [mmu_pkg::SET_BITS-1:0] wr_set_i;
	mmu_pkg::way_t wr_way_i;
	logic wr_auto_i;
	mmu_pkg::tlb_entry_t wr_entry_i;
	logic ready_o;
	logic out_valid_o;
	logic out_ready_i;
	chan_pkg::chan_t out_chan_o;
	mmu_pkg::padr_t out_padr_o;
	logic out_miss_o;
	logic out_fault_o;
	mmu_pkg::rwx_t out_rwx_o;

	// Reference store and per-channel scoreboard
	mmu_pkg::tlb_entry_t model [mmu_pkg::SETS][mmu_pkg::WAYS];
	mmu_pkg::way_t victim;
	req_t pend_q [chan_pkg::CHANNELS][$];
	res_t exp_q [chan_pkg::CHANNELS][$];
	int issued;
	int returned;
	int errors;
	int checks;
	int tests;
	int failed;
	logic [31:0] rng;

	shared_tlb shared_tlb_inst (.*);

	initial clk_g = 1'b0;
	always #(PERIOD / 2) clk_g = ~clk_g;

	// ====================
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic mmu_pkg::tlb_entry_t make_entry(input logic glob,
			input mmu_pkg::asid_t asid, input mmu_pkg::vpn_t vpn,
			input mmu_pkg::ppn_t ppn, input mmu_pkg::rwx_t rwx);
		mmu_pkg::tlb_entry_t e;
		e = '0;
		e[mmu_pkg::E_VALID] = 1'b1;
		e[mmu_pkg::E_GLOBAL] = glob;
		e[mmu_pkg::E_ASID +: 8] = asid;
		// Tag is the VPN above the set index
		e[mmu_pkg::E_TAG +: 16] = vpn[19:4];
		e[mmu_pkg::E_PPN +: 16] = ppn;
		e[mmu_pkg::E_RWX +: 3] = rwx;
		return e;
	endfunction

	// Expected beat, lowest matching way wins
	function automatic res_t predict(input mmu_pkg::vadr_t va, input mmu_pkg::asid_t as,
			input logic we);
		mmu_pkg::tlb_entry_t e;
		mmu_pkg::rwx_t rwx;
		for (int w = 0; w < mmu_pkg::WAYS; w++) begin
			e = model[va[15:12]][w];
			if (e[mmu_pkg::E_VALID] && e[mmu_pkg::E_TAG +: 16] == va[31:16]
				&& (e[mmu_pkg::E_ASID +: 8] == as || e[mmu_pkg::E_GLOBAL])) begin
				rwx = e[mmu_pkg::E_RWX +: 3];
				// Write needs bit 1, read needs bit 2
				return {1'b0, !(we ? rwx[1] : rwx[2]), rwx, e[mmu_pkg::E_PPN +: 16], va[11:0]};
			end
		end
		return {1'b1, 32'd0};
	endfunction

	function automatic void add_req(input int c, input mmu_pkg::vadr_t va,
			input mmu_pkg::asid_t as, input logic we);
		pend_q[c].push_back({we, as, va});
	endfunction

	// ====================
	task automatic write_entry(input mmu_pkg::vpn_t vpn, input mmu_pkg::way_t way,
			input logic auto, input mmu_pkg::tlb_entry_t e);
		@(posedge clk_g);
		wr_valid_i <= 1'b1;
		wr_set_i <= vpn[3:0];
		wr_way_i <= way;
		wr_auto_i <= auto;
		wr_entry_i <= e;
		do @(posedge clk_g); while (!wr_ready_o);
		wr_valid_i <= 1'b0;
	endtask

	// Feeds the pending queues until every beat is back
	task automatic run_traffic(input logic toggle);
		logic [31:0] r;
		req_t q;
		do begin
			@(posedge clk_g);
			r = next_rand();
			for (int c = 0; c < chan_pkg::CHANNELS; c++) begin
				// Valid holds until the transfer
				if (!req_valid_i[c] || req_ready_o[c]) begin
					if (pend_q[c].size() > 0 && (!toggle || r[c])) begin
						q = pend_q[c].pop_front();
						req_valid_i[c] <= 1'b1;
						req_we_i[c] <= q[40];
						req_asid_i[c] <= q[39:32];
						req_vadr_i[c] <= q[31:0];
						issued++;
					end else begin
						req_valid_i[c] <= 1'b0;
					end
				end
			end
			out_ready_i <= !toggle || r[4];
		end while (pend_q[0].size() + pend_q[1].size() + pend_q[2].size() > 0
			|| returned != issued);
		out_ready_i <= 1'b1;
	endtask

	task automatic finish_test(input string name, input int base);
		tests++;
		if (errors != base) begin
			failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - base);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	// ====================
	// Monitor, samples on the edge where transfers happen
	always @(posedge clk_g) begin : monitor
		res_t exp_r;
		res_t got;
		if (!rst_i) begin
			for (int c = 0; c < chan_pkg::CHANNELS; c++)
				if (req_valid_i[c] && req_ready_o[c])
					exp_q[c].push_back(predict(req_vadr_i[c], req_asid_i[c], req_we_i[c]));
			// Mirror the write and the victim rotation
			if (wr_valid_i && wr_ready_o) begin
				if (wr_auto_i) begin
					model[wr_set_i][victim] = wr_entry_i;
					victim = (victim == 2'd3) ? 2'd0 : victim + 2'd1;
				end else begin
					model[wr_set_i][wr_way_i] = wr_entry_i;
				end
			end
			if (out_valid_o && out_ready_i) begin
				checks++;
				returned++;
				assert (out_chan_o < 2'd3 && exp_q[out_chan_o].size() > 0) else begin
					$display("Result beat on channel %0d arrived with no request outstanding",
						out_chan_o);
					errors++;
				end
				if (out_chan_o < 2'd3 && exp_q[out_chan_o].size() > 0) begin
					exp_r = exp_q[out_chan_o].pop_front();
					got = {out_miss_o, out_fault_o, out_rwx_o, out_padr_o};
					assert (got == exp_r) else begin
						$display("** Error at %0t: chan %0d got miss %b fault %b rwx %b padr %h, %s",
							$time, out_chan_o, got[32], got[31], got[30:28], got[27:0],
							$sformatf("expected miss %b fault %b rwx %b padr %h",
							exp_r[32], exp_r[31], exp_r[30:28], exp_r[27:0]));
						errors++;
					end
				end
			end
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG);
		$display("Watchdog expired before the tests completed");
		$display("Verification failed");
		$finish;
	end

	// ====================
	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		mmu_pkg::vpn_t vpn;
		int base;
		rst_i = 1'b1;
		req_valid_i = '0;
		req_vadr_i = '0;
		req_asid_i = '0;
		req_we_i = '0;
		wr_valid_i = 1'b0;
		wr_set_i = '0;
		wr_way_i = '0;
		wr_auto_i = 1'b0;
		wr_entry_i = '0;
		out_ready_i = 1'b1;
		rng = 32'h4a91c7c6;
		victim = '0;
		issued = 0;
		returned = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed = 0;
		// Sweep leaves every entry invalid
		for (int s = 0; s < mmu_pkg::SETS; s++)
			for (int w = 0; w < mmu_pkg::WAYS; w++)
				model[s][w] = '0;
		repeat (RST_CYCLES) @(posedge clk_g);
		rst_i <= 1'b0;
		while (!ready_o) @(posedge clk_g);

		// Empty store misses everywhere
		base = errors;
		for (int c = 0; c < chan_pkg::CHANNELS; c++)
			add_req(c, {20'h12345, 12'h010}, 8'd1, 1'b0);
		run_traffic(1'b0);
		finish_test("1 empty store misses", base);

		// Explicit way, several offsets
		base = errors;
		write_entry(20'h12345, 2'd1, 1'b0, make_entry(1'b0, 8'd1, 20'h12345, 16'habcd, 3'b111));
		add_req(0, {20'h12345, 12'h000}, 8'd1, 1'b0);
		add_req(1, {20'h12345, 12'h7ff}, 8'd1, 1'b1);
		add_req(2, {20'h12345, 12'hfff}, 8'd1, 1'b0);
		run_traffic(1'b0);
		finish_test("2 explicit way hits", base);

		// Foreign ASID misses until the entry turns global
		base = errors;
		write_entry(20'h22226, 2'd0, 1'b0, make_entry(1'b0, 8'd2, 20'h22226, 16'h0042, 3'b110));
		add_req(1, {20'h22226, 12'h123}, 8'd3, 1'b0);
		run_traffic(1'b0);
		write_entry(20'h22226, 2'd0, 1'b0, make_entry(1'b1, 8'd2, 20'h22226, 16'h0042, 3'b110));
		add_req(1, {20'h22226, 12'h123}, 8'd3, 1'b0);
		run_traffic(1'b0);
		finish_test("3 asid and global", base);

		// Read-only page
		base = errors;
		write_entry(20'h33337, 2'd3, 1'b0, make_entry(1'b0, 8'd4, 20'h33337, 16'h7777, 3'b100));
		add_req(0, {20'h33337, 12'h004}, 8'd4, 1'b1);
		add_req(2, {20'h33337, 12'h008}, 8'd4, 1'b1);
		add_req(1, {20'h33337, 12'h00c}, 8'd4, 1'b0);
		run_traffic(1'b0);
		finish_test("4 write fault", base);

		// Fifth auto write evicts the first
		base = errors;
		for (int t = 0; t < 5; t++) begin
			vpn = {16'h0100 + 16'(t), 4'h9};
			write_entry(vpn, 2'd0, 1'b1, make_entry(1'b0, 8'd5, vpn, 16'h0500 + 16'(t), 3'b101));
		end
		for (int t = 0; t < 5; t++)
			add_req(t % 3, {16'h0100 + 16'(t), 4'h9, 12'h0ab}, 8'd5, 1'b0);
		run_traffic(1'b0);
		finish_test("5 auto victim rotation", base);

		// Random mix on all channels under back-pressure
		base = errors;
		for (int c = 0; c < chan_pkg::CHANNELS; c++) begin
			for (int n = 0; n < 40; n++) begin
				r = next_rand();
				r2 = next_rand();
				// Mostly known pages, a few never written
				vpn = (r[2:0] < 3'd6) ? PAGES[r[2:0]] : r2[19:0];
				add_req(c, {vpn, r[19:8]}, {5'd0, r[6:4]}, r[7]);
			end
		end
		run_traffic(1'b1);
		finish_test("6 random traffic", base);

		errors += shared_tlb_inst.u_assert.fail_cnt;
		$display("Summary: %0d tests, %0d failed, %0d beats checked, %0d errors (%0d property)",
			tests, failed, checks, errors, shared_tlb_inst.u_assert.fail_cnt);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/shared_tlb_assertions.sv
// ====================
// Protocol properties of the shared TLB top level
// Bound into every shared_tlb, idle while reset is high
// ====================
`default_nettype none

module shared_tlb_assertions (
	input wire logic clk_g,
	input wire logic rst_i,
	input wire logic [chan_pkg::CHANNELS-1:0] req_valid_i,
	input wire logic [chan_pkg::CHANNELS-1:0] req_ready_i,
	input wire logic ready_i,
	input wire logic wr_ready_i,
	input wire logic out_valid_i,
	input wire logic out_ready_i,
	// Channel, address, miss, fault and rights of the output beat
	input wire logic [34:0] out_beat_i
);

	int fail_cnt;

	initial fail_cnt = 0;

	// At most one channel granted per cycle
	a_grant_onehot: assert property (@(posedge clk_g) disable iff (rst_i)
		$onehot0(req_ready_i))
	else begin
		$error("more than one channel granted in one cycle");
		fail_cnt++;
	end

	// Held beat keeps valid and every field
	a_out_stable: assert property (@(posedge clk_g) disable iff (rst_i)
		(out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_beat_i)))
	else begin
		$error("output beat changed under back-pressure");
		fail_cnt++;
	end

	a_no_early_out: assert property (@(posedge clk_g) disable iff (rst_i)
		!ready_i |-> !out_valid_i)
	else begin
		$error("output valid before the clearing sweep ended");
		fail_cnt++;
	end

	// Writes only into an empty pipeline
	// In flight means a beat at the output or a transfer on the previous edge
	a_wr_idle: assert property (@(posedge clk_g) disable iff (rst_i)
		wr_ready_i |-> (!out_valid_i && !(|(req_valid_i & req_ready_i))
			&& !$past(|(req_valid_i & req_ready_i))))
	else begin
		$error("write ready while a lookup is in flight");
		fail_cnt++;
	end

endmodule

bind shared_tlb shared_tlb_assertions u_assert (
	.clk_g(clk_g),
	.rst_i(rst_i),
	.req_valid_i(req_valid_i),
	.req_ready_i(req_ready_o),
	.ready_i(ready_o),
	.wr_ready_i(wr_ready_o),
	.out_valid_i(out_valid_o),
	.out_ready_i(out_ready_i),
	.out_beat_i({out_chan_o, out_padr_o, out_miss_o, out_fault_o, out_rwx_o})
);

`default_nettype wire

//--- verilog/shared_tlb.sv
// ====================
// Shared TLB top
// Lookups wait for ready_o after the reset sweep
// Host writes wait until no lookup is pending or in flight
// ====================
`default_nettype none

module shared_tlb (
	input wire logic clk_g,
	input wire logic rst_i,
	// Lookup channels
	input wire logic [chan_pkg::CHANNELS-1:0] req_valid_i,
	output logic [chan_pkg::CHANNELS-1:0] req_ready_o,
	input wire mmu_pkg::vadr_t [chan_pkg::CHANNELS-1:0] req_vadr_i,
	input wire mmu_pkg::asid_t [chan_pkg::CHANNELS-1:0] req_asid_i,
	input wire logic [chan_pkg::CHANNELS-1:0] req_we_i,
	// Host entry writes
	input wire logic wr_valid_i,
	output logic wr_ready_o,
	input wire logic [mmu_pkg::SET_BITS-1:0] wr_set_i,
	input wire mmu_pkg::way_t wr_way_i,
	input wire logic wr_auto_i,
	input wire mmu_pkg::tlb_entry_t wr_entry_i,
	output logic ready_o,
	// Result stream
	output logic out_valid_o,
	input wire logic out_ready_i,
	output chan_pkg::chan_t out_chan_o,
	output mmu_pkg::padr_t out_padr_o,
	output logic out_miss_o,
	output logic out_fault_o,
	output mmu_pkg::rwx_t out_rwx_o
);

	tlb_lookup_if lk_if ();

	logic grant_en;
	logic lk_busy;
	logic maint_busy;
	logic [mmu_pkg::WAYS-1:0] ram_we;
	logic [mmu_pkg::SET_BITS-1:0] ram_set;
	mmu_pkg::tlb_entry_t ram_data;

	// No grant in a write cycle
	assign grant_en = ready_o && !(wr_valid_i && wr_ready_o);
	// Pending requests also block writes
	assign maint_busy = lk_busy || (|req_valid_i);

	// ====================
	req_arbiter u_arb (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.req_valid_i(req_valid_i),
		.req_vadr_i(req_vadr_i),
		.req_asid_i(req_asid_i),
		.req_we_i(req_we_i),
		.req_ready_o(req_ready_o),
		.grant_en_i(grant_en),
		.lk(lk_if.arb)
	);

	tlb_maint u_maint (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.wr_valid_i(wr_valid_i),
		.wr_set_i(wr_set_i),
		.wr_way_i(wr_way_i),
		.wr_auto_i(wr_auto_i),
		.wr_entry_i(wr_entry_i),
		.busy_i(maint_busy),
		.wr_ready_o(wr_ready_o),
		.ready_o(ready_o),
		.ram_we_o(ram_we),
		.ram_set_o(ram_set),
		.ram_data_o(ram_data)
	);

	tlb_lookup u_lookup (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.lk(lk_if.pipe),
		.ram_we_i(ram_we),
		.ram_set_i(ram_set),
		.ram_data_i(ram_data),
		.busy_o(lk_busy),
		.out_valid_o(out_valid_o),
		.out_chan_o(out_chan_o),
		.out_padr_o(out_padr_o),
		.out_miss_o(out_miss_o),
		.out_fault_o(out_fault_o),
		.out_rwx_o(out_rwx_o),
		.out_ready_i(out_ready_i)
	);

endmodule

`default_nettype wire

//--- verilog/tlb_lookup.sv
// ====================
// Two-stage lookup pipeline
// Stage one reads all ways, stage two compares into the output
// Everything holds while the output waits for ready
// ====================
`default_nettype none

module tlb_lookup (
	input wire logic clk_g,
	input wire logic rst_i,
	tlb_lookup_if.pipe lk,
	input wire logic [mmu_pkg::WAYS-1:0] ram_we_i,
	input wire logic [mmu_pkg::SET_BITS-1:0] ram_set_i,
	input wire mmu_pkg::tlb_entry_t ram_data_i,
	output logic busy_o,
	output logic out_valid_o,
	output chan_pkg::chan_t out_chan_o,
	output mmu_pkg::padr_t out_padr_o,
	output logic out_miss_o,
	output logic out_fault_o,
	output mmu_pkg::rwx_t out_rwx_o,
	input wire logic out_ready_i
);

	logic adv;
	mmu_pkg::vpn_t req_vpn;
	logic [mmu_pkg::SET_BITS-1:0] rd_set;
	mmu_pkg::tlb_entry_t rdata [mmu_pkg::WAYS];

	// Stage one
	logic s1_valid;
	chan_pkg::chan_t s1_chan;
	logic [mmu_pkg::PAGE_BITS-1:0] s1_off;
	mmu_pkg::tag_t s1_tag;
	mmu_pkg::asid_t s1_asid;
	logic s1_we;

	// Compare results
	logic hit;
	mmu_pkg::tlb_entry_t hit_e;
	mmu_pkg::ppn_t hit_ppn;
	mmu_pkg::rwx_t hit_rwx;

	// Advance when the output is empty or taken
	assign adv = !out_valid_o || out_ready_i;
	assign lk.ready = adv;
	assign busy_o = s1_valid || out_valid_o;

	// Set is the low VPN bits, tag the rest
	assign req_vpn = lk.vadr[31:mmu_pkg::PAGE_BITS];
	assign rd_set = req_vpn[mmu_pkg::SET_BITS-1:0];

	// ====================
	// Ways
	for (genvar w = 0; w < mmu_pkg::WAYS; w++) begin : g_way
		tlb_ram #(
			.DEPTH(mmu_pkg::SETS)
		) u_way (
			.clk_g(clk_g),
			.we_i(ram_we_i[w]),
			.wset_i(ram_set_i),
			.wdata_i(ram_data_i),
			.re_i(adv),
			.rset_i(rd_set),
			.rdata_o(rdata[w])
		);
	end

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			s1_valid <= 1'b0;
		else if (adv)
			s1_valid <= lk.valid;
	end

	always_ff @(posedge clk_g) begin
		if (adv && lk.valid) begin
			s1_chan <= lk.chan;
			s1_off <= lk.vadr[mmu_pkg::PAGE_BITS-1:0];
			s1_tag <= req_vpn[$bits(mmu_pkg::vpn_t)-1:mmu_pkg::SET_BITS];
			s1_asid <= lk.asid;
			s1_we <= lk.we;
		end
	end

	// ====================
	// Lowest matching way wins
	always_comb begin
		hit = 1'b0;
		hit_e = '0;
		for (int w = 0; w < mmu_pkg::WAYS; w++) begin
			if (!hit && rdata[w][mmu_pkg::E_VALID]
				&& rdata[w][mmu_pkg::E_TAG +: $bits(mmu_pkg::tag_t)] == s1_tag
				&& (rdata[w][mmu_pkg::E_ASID +: $bits(mmu_pkg::asid_t)] == s1_asid
				|| rdata[w][mmu_pkg::E_GLOBAL])) begin
				hit = 1'b1;
				hit_e = rdata[w];
			end
		end
	end

	assign hit_ppn = hit_e[mmu_pkg::E_PPN +: $bits(mmu_pkg::ppn_t)];
	assign hit_rwx = hit_e[mmu_pkg::E_RWX +: $bits(mmu_pkg::rwx_t)];

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			out_valid_o <= 1'b0;
		else if (adv)
			out_valid_o <= s1_valid;
	end

	// Miss gives zero address and zero rights
	always_ff @(posedge clk_g) begin
		if (adv && s1_valid) begin
			out_chan_o <= s1_chan;
			out_miss_o <= !hit;
			out_padr_o <= hit ? {hit_ppn, s1_off} : '0;
			out_rwx_o <= hit ? hit_rwx : '0;
			// Write needs W, read needs R
			out_fault_o <= hit && !(s1_we ? hit_rwx[mmu_pkg::RWX_W] : hit_rwx[mmu_pkg::RWX_R]);
		end
	end

endmodule

`default_nettype wire

//--- verilog/tlb_ram.sv
// ====================
// One way of the store
// Registered read, holds its output while re_i is low
// Same set written and read on one edge returns old data
// ====================
`default_nettype none

module tlb_ram #(
	parameter int DEPTH = 16
) (
	input wire logic clk_g,
	input wire logic we_i,
	input wire logic [$clog2(DEPTH)-1:0] wset_i,
	input wire mmu_pkg::tlb_entry_t wdata_i,
	input wire logic re_i,
	input wire logic [$clog2(DEPTH)-1:0] rset_i,
	output mmu_pkg::tlb_entry_t rdata_o
);

	mmu_pkg::tlb_entry_t mem [DEPTH];

	// Write port
	always_ff @(posedge clk_g) begin
		if (we_i)
			mem[wset_i] <= wdata_i;
	end

	// Read port
	always_ff @(posedge clk_g) begin
		if (re_i)
			rdata_o <= mem[rset_i];
	end

endmodule

`default_nettype wire

//--- verilog/tlb_maint.sv
// ====================
// Owns the store write port
// Sweeps every set to the invalid entry after reset
// Then takes host writes while no lookup is busy
// ====================
`default_nettype none

module tlb_maint (
	input wire logic clk_g,
	input wire logic rst_i,
	input wire logic wr_valid_i,
	input wire logic [mmu_pkg::SET_BITS-1:0] wr_set_i,
	input wire mmu_pkg::way_t wr_way_i,
	input wire logic wr_auto_i,
	input wire mmu_pkg::tlb_entry_t wr_entry_i,
	input wire logic busy_i,
	output logic wr_ready_o,
	output logic ready_o,
	output logic [mmu_pkg::WAYS-1:0] ram_we_o,
	output logic [mmu_pkg::SET_BITS-1:0] ram_set_o,
	output mmu_pkg::tlb_entry_t ram_data_o
);

	typedef enum logic {
		ST_INIT,
		ST_RUN
	} maint_state_t;

	maint_state_t state;
	logic [mmu_pkg::SET_BITS-1:0] sweep;
	// Rotating victim for auto writes
	mmu_pkg::way_t victim;
	mmu_pkg::way_t tgt_way;
	logic wr_fire;

	assign ready_o = (state == ST_RUN);
	assign wr_ready_o = (state == ST_RUN) && !busy_i;
	assign wr_fire = wr_valid_i && wr_ready_o;
	assign tgt_way = wr_auto_i ? victim : wr_way_i;

	// ====================
	// Write port steering
	always_comb begin
		ram_we_o = '0;
		ram_set_o = wr_set_i;
		ram_data_o = wr_entry_i;
		if (state == ST_INIT) begin
			// All ways of one set, valid bit clear
			ram_we_o = '1;
			ram_set_o = sweep;
			ram_data_o = '0;
		end else if (wr_fire) begin
			ram_we_o[tgt_way] = 1'b1;
		end
	end

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state <= ST_INIT;
			sweep <= '0;
			victim <= '0;
		end else begin
			case (state)
				ST_INIT: begin
					sweep <= sweep + 1'b1;
					if (sweep == mmu_pkg::SET_BITS'(mmu_pkg::INIT_CYCLES - 1))
						state <= ST_RUN;
				end
				ST_RUN: begin
					// Victim wraps after the last way
					if (wr_fire && wr_auto_i) begin
						if (victim == mmu_pkg::way_t'(mmu_pkg::WAYS - 1))
							victim <= '0;
						else
							victim <= victim + 1'b1;
					end
				end
				default: state <= ST_INIT;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/req_arbiter.sv
// ====================
// Round-robin choice among the lookup channels
// A pending choice is locked until it transfers
// Grants nothing while grant_en_i is low
// ====================
`default_nettype none

module req_arbiter (
	input wire logic clk_g,
	input wire logic rst_i,
	input wire logic [chan_pkg::CHANNELS-1:0] req_valid_i,
	input wire mmu_pkg::vadr_t [chan_pkg::CHANNELS-1:0] req_vadr_i,
	input wire mmu_pkg::asid_t [chan_pkg::CHANNELS-1:0] req_asid_i,
	input wire logic [chan_pkg::CHANNELS-1:0] req_we_i,
	output logic [chan_pkg::CHANNELS-1:0] req_ready_o,
	input wire logic grant_en_i,
	tlb_lookup_if.arb lk
);

	// One-hot priority pointer
	logic [chan_pkg::CHANNELS-1:0] ptr;
	// Offered channel still waiting for ready
	logic lock_q;
	chan_pkg::chan_t lock_ch;
	logic found;
	chan_pkg::chan_t sel;

	// ====================
	// Pick first requester at or after the pointer
	always_comb begin
		found = 1'b0;
		sel = '0;
		if (lock_q) begin
			found = 1'b1;
			sel = lock_ch;
		end else begin
			for (int k = 0; k < chan_pkg::CHANNELS; k++) begin
				for (int c = 0; c < chan_pkg::CHANNELS; c++) begin
					if (!found && ptr[c] && req_valid_i[(c + k) % chan_pkg::CHANNELS]) begin
						found = 1'b1;
						sel = chan_pkg::chan_t'((c + k) % chan_pkg::CHANNELS);
					end
				end
			end
		end
	end

	// Drive the winner onto the lookup port
	assign lk.valid = found && grant_en_i;
	assign lk.chan = sel;
	assign lk.vadr = req_vadr_i[sel];
	assign lk.asid = req_asid_i[sel];
	assign lk.we = req_we_i[sel];

	// Ready goes back to the granted channel only
	always_comb begin
		req_ready_o = '0;
		if (lk.valid && lk.ready)
			req_ready_o[sel] = 1'b1;
	end

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			ptr <= chan_pkg::CHANNELS'(1);
			lock_q <= 1'b0;
			lock_ch <= '0;
		end else begin
			lock_q <= lk.valid && !lk.ready;
			lock_ch <= sel;
			// Next channel after the one served gets top priority
			if (lk.valid && lk.ready)
				ptr <= chan_pkg::CHANNELS'(1) << ((int'(sel) + 1) % chan_pkg::CHANNELS);
		end
	end

endmodule

`default_nettype wire

//--- verilog/tlb_lookup_if.sv
// ====================
// One arbitrated lookup request
// Transfer when valid and ready are both high
// Valid and payload hold until the transfer
// ====================
`default_nettype none

interface tlb_lookup_if;

	logic valid;
	logic ready;
	chan_pkg::chan_t chan;
	mmu_pkg::vadr_t vadr;
	mmu_pkg::asid_t asid;
	// Store access, checks the write permission
	logic we;

	// Arbiter side
	modport arb (output valid, chan, vadr, asid, we, input ready);

	// Pipeline side
	modport pipe (input valid, chan, vadr, asid, we, output ready);

endinterface

`default_nettype wire

//--- verilog/chan_pkg.sv
// ====================
// Request side definitions
// Up to four channels fit in chan_t
// ====================
`default_nettype none

package chan_pkg;

	// Number of lookup requesters
	localparam int CHANNELS = 3;

	// Channel number carried with each lookup
	typedef logic [1:0] chan_t;

endpackage

`default_nettype wire

//--- verilog/mmu_pkg.sv
// ====================
// Translation side types for the shared TLB
// 4 kB pages, 4 ways of 16 sets, 28-bit physical space
// An entry is 46 bits so that all six fields fit above the spare bit
// ====================
`default_nettype none

package mmu_pkg;

	// Geometry
	localparam int PAGE_BITS = 12;
	localparam int SET_BITS = 4;
	localparam int SETS = 1 << SET_BITS;
	localparam int WAYS = 4;
	// Sweep clears one set per cycle
	localparam int INIT_CYCLES = SETS;

	typedef logic [31:0] vadr_t;
	typedef logic [27:0] padr_t;
	typedef logic [19:0] vpn_t;
	typedef logic [15:0] tag_t;
	typedef logic [1:0] way_t;
	typedef logic [7:0] asid_t;
	typedef logic [15:0] ppn_t;
	// Read on top, execute at bit 0
	typedef logic [2:0] rwx_t;

	localparam int RWX_R = 2;
	localparam int RWX_W = 1;

	// ====================
	// Entry field offsets, bit 0 spare
	localparam int E_RWX = 1;
	localparam int E_PPN = E_RWX + $bits(rwx_t);
	localparam int E_TAG = E_PPN + $bits(ppn_t);
	localparam int E_ASID = E_TAG + $bits(tag_t);
	localparam int E_GLOBAL = E_ASID + $bits(asid_t);
	localparam int E_VALID = E_GLOBAL + 1;
	localparam int ENTRY_BITS = E_VALID + 1;

	typedef logic [ENTRY_BITS-1:0] tlb_entry_t;

endpackage

`default_nettype wire
